/* Makefile */
TOOL     = verilator
FLAGS    = --binary --timing
TOP      = tbMulticycleCore
FILELIST = verilog.f
OBJDIR   = obj_dir
LOG      = sim.log
PASSMSG  = Everything OK

.PHONY: all lint sim clean

all: sim

lint:
	$(TOOL) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASSMSG)" $(LOG) && echo "Simulation passed" || \
		(echo "Simulation failed"; exit 1)

clean:
	rm -rf $(OBJDIR) $(LOG)

/* rtl/aluDecoder.sv */
`timescale 1ns/1ns

module aluDecoder (
	input rvPkg::aluOpT aluOp,
	input logic [2:0] funct3,
	input logic opcode5,
	input logic funct7b5,
	output rvPkg::aluCtrlT aluControl
);
	import rvPkg::*;

	always_comb begin
		case (aluOp)
			aluAdd: aluControl = ctlAdd;
			aluSub: aluControl = ctlSub;
			default: begin
				case (funct3)
					3'b000: begin
						// Only R-type sub has both bits set
						if (opcode5 && funct7b5)
							aluControl = ctlSub;
						else
							aluControl = ctlAdd;
					end
					3'b010: aluControl = ctlSlt;
					3'b110: aluControl = ctlOr;
					3'b111: aluControl = ctlAnd;
					default: aluControl = ctlAdd;
				endcase
			end
		endcase
	end

endmodule

/* rtl/controlFsm.sv */
`timescale 1ns/1ns

module controlFsm (
	input logic clk,
	input logic reset,
	input rvPkg::opcodeT opcode,
	output logic adrSrc,
	output logic irWrite,
	output logic regWrite,
	output logic pcUpdate,
	output logic memWrite,
	output logic branch,
	output rvPkg::srcASelT aluSrcA,
	output rvPkg::srcBSelT aluSrcB,
	output rvPkg::aluOpT aluOp,
	output rvPkg::resultSelT resultSrc
);
	import rvPkg::*;

	fsmStateT state, nextState;

	always_ff @(posedge clk) begin
		if (reset)
			state <= stFetch;
		else
			state <= nextState;
	end

	always_comb begin
		case (state)
			stFetch: nextState = stDecode;
			stDecode: begin
				case (opcode)
					opLoad, opStore: nextState = stMemAdr;
					opRType: nextState = stExecuteR;
					opIType: nextState = stExecuteI;
					opBranch: nextState = stBeq;
					opJal: nextState = stJal;
					default: nextState = stFetch; // Unknown opcode, nothing written
				endcase
			end
			stMemAdr: nextState = (opcode == opLoad) ? stMemRead : stMemWrite;
			stMemRead: nextState = stMemWb;
			stExecuteR, stExecuteI: nextState = stAluWb;
			stJal: nextState = stAluWb; // Link write of old PC + 4
			default: nextState = stFetch;
		endcase
	end

	// Moore outputs
	always_comb begin
		adrSrc = 1'b0;
		irWrite = 1'b0;
		regWrite = 1'b0;
		pcUpdate = 1'b0;
		memWrite = 1'b0;
		branch = 1'b0;
		aluSrcA = selPc;
		aluSrcB = selRegB;
		aluOp = aluAdd;
		resultSrc = selAluOut;
		case (state)
			stFetch: begin
				irWrite = 1'b1;
				pcUpdate = 1'b1;
				aluSrcB = selFour; // PC + 4
				resultSrc = selAluResult;
			end
			stDecode: begin
				// Branch or jump target into the ALU output register
				aluSrcA = selOldPc;
				aluSrcB = selImm;
			end
			stMemAdr: begin
				aluSrcA = selRegA;
				aluSrcB = selImm;
			end
			stMemRead: adrSrc = 1'b1;
			stMemWb: begin
				resultSrc = selData;
				regWrite = 1'b1;
			end
			stMemWrite: begin
				adrSrc = 1'b1;
				memWrite = 1'b1;
			end
			stExecuteR: begin
				aluSrcA = selRegA;
				aluOp = aluFunct;
			end
			stExecuteI: begin
				aluSrcA = selRegA;
				aluSrcB = selImm;
				aluOp = aluFunct;
			end
			stAluWb: regWrite = 1'b1;
			stBeq: begin
				aluSrcA = selRegA;
				aluOp = aluSub;
				branch = 1'b1;
			end
			stJal: begin
				aluSrcA = selOldPc;
				aluSrcB = selFour;
				pcUpdate = 1'b1; // Target from decode cycle
			end
			default: ;
		endcase
	end

endmodule

/* rtl/coreDatapath.sv */
`timescale 1ns/1ns
`include "core_cfg.svh"

module coreDatapath (
	input logic clk,
	input logic reset,
	ctrlBus.datapathSide ctrl,
	input logic [`XLEN-1:0] baseAddr,
	input logic [`XLEN-1:0] writeData,
	input logic [`XLEN-1:0] immExt,
	input logic [`XLEN-1:0] memReadData,
	output logic [`XLEN-1:0] instr,
	output logic [`XLEN-1:0] resultData,
	output logic [`XLEN-1:0] memAddr,
	output logic [`XLEN-1:0] memWriteData,
	output logic memWrite
);
	import rvPkg::*;

	logic [`XLEN-1:0] pc, oldPc;
	logic [`XLEN-1:0] dataReg, regA, regB, aluOut;
	logic [`XLEN-1:0] srcA, srcB, aluResult;
	logic zero;
	logic pcWrite;

	assign pcWrite = ctrl.pcUpdate | (ctrl.branch & zero);

	always_ff @(posedge clk) begin
		if (reset)
			pc <= `RESET_PC;
		else if (pcWrite)
			pc <= resultData;
	end

	// Instruction and its own PC latched together
	always_ff @(posedge clk) begin
		if (ctrl.irWrite) begin
			instr <= memReadData;
			oldPc <= pc;
		end
	end

	// Stage registers between cycles
	always_ff @(posedge clk) begin
		dataReg <= memReadData;
		regA <= baseAddr;
		regB <= writeData;
		aluOut <= aluResult;
	end

	always_comb begin
		case (ctrl.aluSrcA)
			selPc: srcA = pc;
			selOldPc: srcA = oldPc;
			selRegA: srcA = regA;
			default: srcA = '0;
		endcase
		case (ctrl.aluSrcB)
			selRegB: srcB = regB;
			selImm: srcB = immExt;
			selFour: srcB = `XLEN'd4;
			default: srcB = '0;
		endcase
	end

	always_comb begin
		case (ctrl.aluControl)
			ctlAdd: aluResult = srcA + srcB;
			ctlSub: aluResult = srcA - srcB;
			ctlAnd: aluResult = srcA & srcB;
			ctlOr: aluResult = srcA | srcB;
			ctlSlt: aluResult = {{(`XLEN-1){1'b0}}, $signed(srcA) < $signed(srcB)};
			default: aluResult = '0;
		endcase
	end

	assign zero = (aluResult == '0);

	always_comb begin
		case (ctrl.resultSrc)
			selAluOut: resultData = aluOut;
			selData: resultData = dataReg;
			selAluResult: resultData = aluResult;
			default: resultData = '0;
		endcase
	end

	assign memAddr = ctrl.adrSrc ? resultData : pc; // Data access or fetch
	assign memWriteData = regB;
	assign memWrite = ctrl.memWrite;

endmodule

/* rtl/core_cfg.svh */
`ifndef CORE_CFG_SVH
`define CORE_CFG_SVH

// Data and address width
`define XLEN 32

`define NUM_REGS 32
`define REG_AW 5

`define RESET_PC 32'h0000_0000

`endif

/* rtl/ctrlBus.sv */
`timescale 1ns/1ns

interface ctrlBus;
	import rvPkg::*;

	logic adrSrc; // Memory address from result instead of PC
	logic irWrite;
	logic pcUpdate;
	logic branch;
	logic memWrite;
	srcASelT aluSrcA;
	srcBSelT aluSrcB;
	resultSelT resultSrc;
	aluCtrlT aluControl;

	modport decodeSide (
		output adrSrc, irWrite, pcUpdate, branch, memWrite,
		output aluSrcA, aluSrcB, resultSrc, aluControl
	);

	modport datapathSide (
		input adrSrc, irWrite, pcUpdate, branch, memWrite,
		input aluSrcA, aluSrcB, resultSrc, aluControl
	);

endinterface

/* rtl/instructionDecode.sv */
`timescale 1ns/1ns
`include "core_cfg.svh"

module instructionDecode (
	input logic clk,
	input logic reset,
	input logic [`XLEN-1:0] instr,
	input logic [`XLEN-1:0] resultData,
	ctrlBus.decodeSide ctrl,
	output logic [`XLEN-1:0] baseAddr,
	output logic [`XLEN-1:0] writeData,
	output logic [`XLEN-1:0] immExt
);
	import rvPkg::*;

	opcodeT opcode;
	aluOpT aluOp;
	logic regWrite;
	logic [2:0] funct3;
	logic funct7b5;
	logic [`REG_AW-1:0] rd, rs1, rs2;

	assign opcode = opcodeT'(instr[6:0]);

	// Register fields per format, missing ones forced to zero
	always_comb begin
		rd = '0;
		rs1 = '0;
		rs2 = '0;
		funct3 = 3'b000;
		funct7b5 = 1'b0;
		case (opcode)
			opRType: begin
				rd = instr[11:7];
				rs1 = instr[19:15];
				rs2 = instr[24:20];
				funct3 = instr[14:12];
				funct7b5 = instr[30];
			end
			opIType: begin
				rd = instr[11:7];
				rs1 = instr[19:15];
				funct3 = instr[14:12];
			end
			opLoad: begin
				rd = instr[11:7];
				rs1 = instr[19:15];
			end
			opStore, opBranch: begin
				rs1 = instr[19:15];
				rs2 = instr[24:20];
			end
			opJal: rd = instr[11:7];
			default: ;
		endcase
	end

	always_comb begin
		case (opcode)
			opLoad, opIType: immExt = {{20{instr[31]}}, instr[31:20]};
			opStore: immExt = {{20{instr[31]}}, instr[31:25], instr[11:7]};
			opBranch: immExt = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
			opJal: immExt = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
			default: immExt = '0;
		endcase
	end

	controlFsm fsm (
		.clk(clk),
		.reset(reset),
		.opcode(opcode),
		.adrSrc(ctrl.adrSrc),
		.irWrite(ctrl.irWrite),
		.regWrite(regWrite),
		.pcUpdate(ctrl.pcUpdate),
		.memWrite(ctrl.memWrite),
		.branch(ctrl.branch),
		.aluSrcA(ctrl.aluSrcA),
		.aluSrcB(ctrl.aluSrcB),
		.aluOp(aluOp),
		.resultSrc(ctrl.resultSrc)
	);

	aluDecoder aluDec (
		.aluOp(aluOp),
		.funct3(funct3),
		.opcode5(instr[5]), // Set for R-type, clear for I-type
		.funct7b5(funct7b5),
		.aluControl(ctrl.aluControl)
	);

	registerFile regFile (
		.clk(clk),
		.addr1(rs1),
		.addr2(rs2),
		.addr3(rd),
		.regWrite(regWrite),
		.dataIn(resultData),
		.rd1(baseAddr),
		.rd2(writeData)
	);

endmodule

/* rtl/multicycleCore.sv */
`timescale 1ns/1ns
`include "core_cfg.svh"

module multicycleCore (
	input logic clk,
	input logic reset,
	input logic [`XLEN-1:0] memReadData,
	output logic [`XLEN-1:0] memAddr,
	output logic [`XLEN-1:0] memWriteData,
	output logic memWrite
);

	logic [`XLEN-1:0] instr, resultData;
	logic [`XLEN-1:0] baseAddr, writeData, immExt;

	ctrlBus ctrl ();

	instructionDecode decodeUnit (
		.clk(clk),
		.reset(reset),
		.instr(instr),
		.resultData(resultData),
		.ctrl(ctrl.decodeSide),
		.baseAddr(baseAddr),
		.writeData(writeData),
		.immExt(immExt)
	);

	coreDatapath datapathUnit (
		.clk(clk),
		.reset(reset),
		.ctrl(ctrl.datapathSide),
		.baseAddr(baseAddr),
		.writeData(writeData),
		.immExt(immExt),
		.memReadData(memReadData),
		.instr(instr),
		.resultData(resultData),
		.memAddr(memAddr),
		.memWriteData(memWriteData),
		.memWrite(memWrite)
	);

endmodule

/* rtl/registerFile.sv */
`timescale 1ns/1ns
`include "core_cfg.svh"

module registerFile (
	input logic clk,
	input logic [`REG_AW-1:0] addr1,
	input logic [`REG_AW-1:0] addr2,
	input logic [`REG_AW-1:0] addr3,
	input logic regWrite,
	input logic [`XLEN-1:0] dataIn,
	output logic [`XLEN-1:0] rd1,
	output logic [`XLEN-1:0] rd2
);

	logic [`XLEN-1:0] regs [`NUM_REGS];

	always_ff @(posedge clk) begin
		if (regWrite && (addr3 != '0))
			regs[addr3] <= dataIn;
	end

	// x0 always reads zero
	assign rd1 = (addr1 == '0) ? '0 : regs[addr1];
	assign rd2 = (addr2 == '0) ? '0 : regs[addr2];

endmodule

/* rtl/rvPkg.sv */
package rvPkg;

	// Major opcodes of the supported subset
	typedef enum logic [6:0] {
		opLoad   = 7'b0000011,
		opStore  = 7'b0100011,
		opRType  = 7'b0110011,
		opIType  = 7'b0010011,
		opBranch = 7'b1100011,
		opJal    = 7'b1101111
	} opcodeT;

	typedef enum logic [3:0] {
		stFetch,
		stDecode,
		stMemAdr,
		stMemRead,
		stMemWb,
		stMemWrite,
		stExecuteR,
		stExecuteI,
		stAluWb,
		stBeq,
		stJal
	} fsmStateT;

	typedef enum logic [1:0] {
		aluAdd   = 2'b00, // Address and PC math
		aluSub   = 2'b01, // Branch compare
		aluFunct = 2'b10  // From funct3/funct7
	} aluOpT;

	typedef enum logic [2:0] {
		ctlAdd = 3'b000,
		ctlSub = 3'b001,
		ctlAnd = 3'b010,
		ctlOr  = 3'b011,
		ctlSlt = 3'b101
	} aluCtrlT;

	typedef enum logic [1:0] {selPc, selOldPc, selRegA} srcASelT;
	typedef enum logic [1:0] {selRegB, selImm, selFour} srcBSelT;
	typedef enum logic [1:0] {selAluOut, selData, selAluResult} resultSelT;

endpackage

/* testbench/tbChecker.sv */
`timescale 1ns/1ns
`include "core_cfg.svh"

module tbChecker (
	input logic clk,
	input logic reset,
	input logic [31:0] memAddr,
	input logic [31:0] memWriteData,
	input logic memWrite,
	output int valueErrors,
	output int otherErrors,
	output int storesSeen,
	output int storesExpected,
	output logic done
);

	logic [31:0] modelMem [512];
	logic [31:0] xr [32];
	logic [31:0] expAddr [$];
	logic [31:0] expData [$];
	logic modelReady = 1'b0;
	logic sawReset = 1'b0;
	logic startChecked = 1'b0;
	int idleCycles = 0;
	logic idleReported = 1'b0;

	task automatic loadWord(input int addr, input logic [31:0] w);
		modelMem[9'(addr)] = w;
	endtask

	function automatic logic [31:0] immI(input logic [31:0] i);
		return {{20{i[31]}}, i[31:20]};
	endfunction

	function automatic logic [31:0] immS(input logic [31:0] i);
		return {{20{i[31]}}, i[31:25], i[11:7]};
	endfunction

	function automatic logic [31:0] immB(input logic [31:0] i);
		return {{20{i[31]}}, i[7], i[30:25], i[11:8], 1'b0};
	endfunction

	function automatic logic [31:0] immJ(input logic [31:0] i);
		return {{12{i[31]}}, i[19:12], i[20], i[30:21], 1'b0};
	endfunction

	task automatic writeReg(input logic [4:0] rd, input logic [31:0] v);
		if (rd != 5'd0)
			xr[rd] = v; // x0 stays zero
	endtask

	function automatic logic [31:0] aluModel(input logic [2:0] f3, input logic isSub,
		input logic [31:0] a, input logic [31:0] b);
		case (f3)
			3'b000: return isSub ? a - b : a + b;
			3'b010: return {31'b0, $signed(a) < $signed(b)};
			3'b110: return a | b;
			3'b111: return a & b;
			default: return 32'h0;
		endcase
	endfunction

	// Runs the whole program once and records every store in order
	task automatic prepareModel();
		logic [31:0] pc, ins, a, b, addr;
		logic stop;
		int steps;
		valueErrors = 0;
		otherErrors = 0;
		storesSeen = 0;
		done = 1'b0;
		for (int r = 0; r < 32; r++)
			xr[5'(r)] = 32'h0;
		pc = `RESET_PC;
		stop = 1'b0;
		steps = 0;
		while (!stop && steps < 10000) begin
			ins = modelMem[pc[10:2]];
			a = xr[ins[19:15]];
			b = xr[ins[24:20]];
			steps++;
			case (ins[6:0])
				7'b0110011: begin
					writeReg(ins[11:7], aluModel(ins[14:12], ins[30], a, b));
					pc = pc + 4;
				end
				7'b0010011: begin
					writeReg(ins[11:7], aluModel(ins[14:12], 1'b0, a, immI(ins)));
					pc = pc + 4;
				end
				7'b0000011: begin
					addr = a + immI(ins);
					writeReg(ins[11:7], modelMem[addr[10:2]]);
					pc = pc + 4;
				end
				7'b0100011: begin
					addr = a + immS(ins);
					modelMem[addr[10:2]] = b;
					expAddr.push_back(addr);
					expData.push_back(b);
					pc = pc + 4;
				end
				7'b1100011: pc = (a == b) ? pc + immB(ins) : pc + 4;
				7'b1101111: begin
					if (immJ(ins) == 32'h0)
						stop = 1'b1; // Self loop ends the program
					else begin
						writeReg(ins[11:7], pc + 4);
						pc = pc + immJ(ins);
					end
				end
				default: pc = pc + 4;
			endcase
		end
		if (!stop) begin
			$display("Model never reached the final loop");
			otherErrors++;
		end
		storesExpected = expAddr.size();
		modelReady = 1'b1;
	endtask

	task automatic reportMismatch(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		$display("[FAIL] %0t %s: got %h, expected %h", $time, name, got, exp);
		valueErrors++;
	endtask

	always @(posedge clk) begin
		if (reset)
			sawReset = 1'b1;
		else if (sawReset) begin
			if (!startChecked) begin // First cycle out of reset
				startChecked = 1'b1;
				if (memAddr !== `RESET_PC)
					reportMismatch("memAddr", memAddr, `RESET_PC);
				if (memWrite !== 1'b0)
					reportMismatch("memWrite", {31'b0, memWrite}, 32'h0);
			end
			if (memWrite === 1'b1) begin
				idleCycles = 0;
				if (storesSeen >= storesExpected) begin
					$display("Unexpected extra store to address %h at %0t", memAddr, $time);
					otherErrors++;
				end else begin
					if (memAddr !== expAddr[storesSeen])
						reportMismatch("memAddr", memAddr, expAddr[storesSeen]);
					if (memWriteData !== expData[storesSeen])
						reportMismatch("memWriteData", memWriteData, expData[storesSeen]);
				end
				storesSeen++;
			end else if (!done) begin
				idleCycles++;
				if (idleCycles > 2000 && !idleReported) begin
					$display("No store on the memory bus for 2000 cycles");
					idleReported = 1'b1;
					otherErrors++;
				end
			end
			done = modelReady && (storesSeen >= storesExpected);
		end
	end

endmodule

/* testbench/tbMulticycleCore.sv */
`timescale 1ns/1ns

module tbMulticycleCore;

	logic clk;
	logic reset;
	logic [31:0] memReadData, memAddr, memWriteData;
	logic memWrite;
	logic [31:0] mem [512];
	logic [31:0] image [512];
	logic [31:0] lfsr;
	int valueErrors, otherErrors, storesSeen, storesExpected;
	logic done;
	int waitCycles;

	multicycleCore multicycleCore_inst (
		.clk(clk),
		.reset(reset),
		.memReadData(memReadData),
		.memAddr(memAddr),
		.memWriteData(memWriteData),
		.memWrite(memWrite)
	);

	tbChecker checkUnit (
		.clk(clk),
		.reset(reset),
		.memAddr(memAddr),
		.memWriteData(memWriteData),
		.memWrite(memWrite),
		.valueErrors(valueErrors),
		.otherErrors(otherErrors),
		.storesSeen(storesSeen),
		.storesExpected(storesExpected),
		.done(done)
	);

	// Combinational read
	assign memReadData = mem[memAddr[10:2]];

	// Image reloaded on every reset cycle
	always @(posedge clk) begin
		if (reset) begin
			for (int a = 0; a < 512; a++)
				mem[9'(a)] <= image[9'(a)];
		end else if (memWrite)
			mem[memAddr[10:2]] <= memWriteData;
	end

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// Fibonacci LFSR with taps 32 22 2 1
	function automatic logic nextBit();
		logic newBit;
		newBit = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
		lfsr = {lfsr[30:0], newBit};
		return newBit;
	endfunction

	function automatic logic [31:0] randBits(input int n);
		logic [31:0] v;
		v = 32'h0;
		for (int k = 0; k < n; k++)
			v = {v[30:0], nextBit()};
		return v;
	endfunction

	function automatic logic [31:0] encR(input logic f7b5, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
		return {1'b0, f7b5, 5'b0, rs2, rs1, f3, rd, 7'b0110011};
	endfunction

	function automatic logic [31:0] encI(input logic [11:0] imm, input logic [4:0] rs1,
		input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] op);
		return {imm, rs1, f3, rd, op};
	endfunction

	function automatic logic [31:0] encS(input logic [11:0] imm, input logic [4:0] rs2,
		input logic [4:0] rs1);
		return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
	endfunction

	function automatic logic [31:0] encB(input logic [12:0] imm, input logic [4:0] rs2,
		input logic [4:0] rs1);
		return {imm[12], imm[10:5], rs2, rs1, 3'b000, imm[4:1], imm[11], 7'b1100011};
	endfunction

	function automatic logic [31:0] encJ(input logic [20:0] imm, input logic [4:0] rd);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
	endfunction

	task automatic buildProgram();
		int idx, kind, k;
		int epiStart;
		logic [4:0] rd, rs1, rs2;
		logic [11:0] imm12, off;
		logic [31:0] addr;
		for (int a = 0; a < 512; a++) begin
			addr = 32'(a) << 2;
			image[9'(a)] = (addr * 32'h9E3779B1) ^ 32'h5A5A0F0F;
		end
		idx = 0;
		epiStart = 91;
		for (int r = 1; r < 32; r++) begin // Defined value in every register
			imm12 = 12'(randBits(12));
			image[9'(idx)] = encI(imm12, 5'd0, 3'b000, 5'(r), 7'b0010011);
			idx++;
		end
		for (int n = 0; n < 60; n++) begin
			kind = int'(randBits(4));
			rd = 5'(randBits(5));
			rs1 = 5'(randBits(5));
			rs2 = 5'(randBits(5));
			imm12 = 12'(randBits(12));
			off = 12'(32'h400 + (randBits(8) << 2)); // Data region
			k = 1 + int'(randBits(2));
			if (idx + k > epiStart)
				k = epiStart - idx;
			case (kind)
				0: image[9'(idx)] = encR(1'b0, rs2, rs1, 3'b000, rd);
				1: image[9'(idx)] = encR(1'b1, rs2, rs1, 3'b000, rd);
				2: image[9'(idx)] = encR(1'b0, rs2, rs1, 3'b111, rd);
				3: image[9'(idx)] = encR(1'b0, rs2, rs1, 3'b110, rd);
				4: image[9'(idx)] = encR(1'b0, rs2, rs1, 3'b010, rd);
				6: image[9'(idx)] = encI(imm12, rs1, 3'b111, rd, 7'b0010011);
				7: image[9'(idx)] = encI(imm12, rs1, 3'b110, rd, 7'b0010011);
				8: image[9'(idx)] = encI(imm12, rs1, 3'b010, rd, 7'b0010011);
				9: image[9'(idx)] = encI(off, 5'd0, 3'b010, rd, 7'b0000011);
				10: image[9'(idx)] = encS(off, rs2, 5'd0);
				11: image[9'(idx)] = encB(13'(k * 4), rs2, rs1);
				12: image[9'(idx)] = encJ(21'(k * 4), rd);
				default: image[9'(idx)] = encI(imm12, rs1, 3'b000, rd, 7'b0010011);
			endcase
			idx++;
		end
		for (int r = 1; r < 32; r++) begin
			image[9'(idx)] = encS(12'(32'h700 + 4 * r), 5'(r), 5'd0);
			idx++;
		end
		image[9'(idx)] = encJ(21'd0, 5'd0); // jal x0,0
		for (int a = 0; a < 512; a++)
			checkUnit.loadWord(a, image[9'(a)]);
		checkUnit.prepareModel();
	endtask

	initial begin
		reset = 1'b1;
		lfsr = 32'd71914;
		buildProgram();
		repeat (5) @(posedge clk);
		#2 reset = 1'b0;
		waitCycles = 0;
		while (!done && waitCycles < 20000) begin
			@(posedge clk);
			waitCycles++;
		end
		if (!done)
			$display("Timeout with %0d of %0d stores seen", storesSeen, storesExpected);
		else
			repeat (40) @(posedge clk); // Core spins on the final jal
		$display("Errors: %0d value, %0d other; stores %0d of %0d",
			valueErrors, otherErrors, storesSeen, storesExpected);
		if (done && valueErrors == 0 && otherErrors == 0 && storesSeen == storesExpected)
			$display("Everything OK");
		else
			$display("Something failed");
		$finish;
	end

endmodule

/* verilog.f */
+incdir+rtl
rtl/rvPkg.sv
rtl/ctrlBus.sv
rtl/controlFsm.sv
rtl/aluDecoder.sv
rtl/registerFile.sv
rtl/instructionDecode.sv
rtl/coreDatapath.sv
rtl/multicycleCore.sv
testbench/tbChecker.sv
testbench/tbMulticycleCore.sv
